// File: compile.f
pmp_pkg.sv
pmp_csr_ctrl.sv
pmp_entry_regs.sv
pmp_addr_match.sv
pmp_perm_check.sv
pmp_top.sv
tb_pmp_clk.sv
tb_pmp.sv

// File: pmp_addr_match.sv
// pmp_addr_match: one entry's address matcher for fetch and load/store
`timescale 1ns/1ps

module pmp_addr_match
  import pmp_pkg::*;
(
  input  pmp_mode_e cfg_mode,
  input  pmpaddr_t  entry_addr,
  input  paddr_t    ifu_addr,
  input  paddr_t    lsu_addr,
  input  logic      ifu_ge_prev,
  input  logic      lsu_ge_prev,
  output logic      ifu_ge,
  output logic      lsu_ge,
  output logic      ifu_hit,
  output logic      lsu_hit
);

  // word addresses of both ports
  pmpaddr_t ifu_word;
  pmpaddr_t lsu_word;
  // napot bits that must compare equal
  pmpaddr_t napot_care;

  // hit for one port under the entry mode
  function automatic logic mode_hit(pmp_mode_e mode, pmpaddr_t word,
                                    pmpaddr_t base, pmpaddr_t care,
                                    logic ge_prev, logic ge);
    logic hit;
    case (mode)
      // [previous entry, this entry)
      TOR:     hit = ge_prev & ~ge;
      NA4:     hit = (word == base);
      NAPOT:   hit = ((word ^ base) & care) == '0;
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  assign ifu_word = ifu_addr[31:2];
  assign lsu_word = lsu_addr[31:2];

  // trailing ones plus the next zero mark the region offset bits
  // e.g. ...0111 gives 4 don't-care word bits for a 64 byte region
  assign napot_care = ~(entry_addr ^ (entry_addr + pmpaddr_t'(1)));

  // ge results also feed the next entry's TOR bottom
  assign ifu_ge = (ifu_word >= entry_addr);
  assign lsu_ge = (lsu_word >= entry_addr);

  assign ifu_hit = mode_hit(cfg_mode, ifu_word, entry_addr, napot_care,
                            ifu_ge_prev, ifu_ge);
  assign lsu_hit = mode_hit(cfg_mode, lsu_word, entry_addr, napot_care,
                            lsu_ge_prev, lsu_ge);

endmodule

// File: pmp_csr_ctrl.sv
// pmp_csr_ctrl: csr select decode, lock write rules and csr read mux
`timescale 1ns/1ps

module pmp_csr_ctrl
  import pmp_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  pmp_csr_req_t                  csr_req,
  input  pmp_cfg_t [NUM_ENTRIES-1:0]    cfg,
  input  pmpaddr_t [NUM_ENTRIES-1:0]    addr,
  output logic     [NUM_ENTRIES-1:0]    cfg_wen,
  output logic     [NUM_ENTRIES-1:0]    addr_wen,
  output csr_data_t                     wdata,
  output csr_data_t                     csr_rdata
);

  // number of pmpcfg words whose selects sit below the pmpaddr ones
  localparam int NUM_CFG_CSR = NUM_ENTRIES / CFG_PER_CSR;

  // selects qualified by the write strobe
  csr_sel_t sel_wr;
  // entry i+1 is a locked TOR entry, so pmpaddr i is its bottom
  logic [NUM_ENTRIES-1:0] tor_above;

  // csr byte layout of one stored config
  function automatic cfg_byte_t cfg_to_byte(pmp_cfg_t c);
    return {c.lock, 2'b00, c.mode, c.exec, c.write, c.read};
  endfunction

  assign sel_wr = csr_req.sel & {CSR_SEL_W{csr_req.wen}};

  // write data goes to storage unchanged
  assign wdata = csr_req.wdata;

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_tor_lock
    if (i == NUM_ENTRIES - 1) begin : g_last
      // nothing above the top entry
      assign tor_above[i] = 1'b0;
    end else begin : g_mid
      assign tor_above[i] = cfg[i+1].lock & (cfg[i+1].mode == TOR);
    end
  end

  // per-entry write enables after the lock rules
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // cfg byte frozen by its own lock
      cfg_wen[i]  = sel_wr[i / CFG_PER_CSR] & ~cfg[i].lock;
      // address frozen by own lock or by a locked TOR above
      addr_wen[i] = sel_wr[NUM_CFG_CSR + i] & ~cfg[i].lock & ~tor_above[i];
    end
  end

  // one-hot selects let the read mux be an or-tree
  always_comb begin
    csr_rdata = '0;
    for (int c = 0; c < NUM_CFG_CSR; c++) begin
      if (csr_req.sel[c]) begin
        for (int b = 0; b < CFG_PER_CSR; b++) begin
          csr_rdata[8*b +: 8] = csr_rdata[8*b +: 8] | cfg_to_byte(cfg[c*CFG_PER_CSR + b]);
        end
      end
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // pmpaddr reads back with two zero msbs
      if (csr_req.sel[NUM_CFG_CSR + i]) begin
        csr_rdata = csr_rdata | {2'b00, addr[i]};
      end
    end
  end

endmodule

// File: pmp_entry_regs.sv
// pmp_entry_regs: per-entry config and address registers
`timescale 1ns/1ps

module pmp_entry_regs
  import pmp_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic                          cpuclk,
  input  logic                          rst,
  input  logic     [NUM_ENTRIES-1:0]    cfg_wen,
  input  logic     [NUM_ENTRIES-1:0]    addr_wen,
  input  csr_data_t                     wdata,
  output pmp_cfg_t [NUM_ENTRIES-1:0]    cfg,
  output pmpaddr_t [NUM_ENTRIES-1:0]    addr
);

  // unpack a csr byte without reserved bits 6:5
  function automatic pmp_cfg_t byte_to_cfg(cfg_byte_t b);
    pmp_cfg_t c;
    c.lock  = b[7];
    c.mode  = pmp_mode_e'(b[4:3]);
    c.exec  = b[2];
    c.write = b[1];
    c.read  = b[0];
    return c;
  endfunction

  always_ff @(posedge cpuclk) begin
    if (rst) begin
      // all entries OFF, unlocked, address zero
      cfg  <= '0;
      addr <= '0;
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        // byte lane by position within the pmpcfg word
        if (cfg_wen[i]) begin
          cfg[i] <= byte_to_cfg(wdata[8*(i % CFG_PER_CSR) +: 8]);
        end
        // only word address bits are kept
        if (addr_wen[i]) begin
          addr[i] <= wdata[$bits(pmpaddr_t)-1:0];
        end
      end
    end
  end

endmodule

// File: pmp_perm_check.sv
// pmp_perm_check: lowest-index hit select, lsu privilege and allow/deny decision
`timescale 1ns/1ps

module pmp_perm_check
  import pmp_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  pmp_cfg_t [NUM_ENTRIES-1:0] cfg,
  input  logic     [NUM_ENTRIES-1:0] ifu_hit,
  input  logic     [NUM_ENTRIES-1:0] lsu_hit,
  input  logic                       ifu_machine_mode,
  input  logic                       lsu_write,
  input  logic                       mach_mode,
  input  logic                       mstatus_mprv,
  input  logic     [1:0]             mstatus_mpp,
  output logic                       ifu_deny,
  output logic                       lsu_deny
);

  // config of the winning entry per port
  pmp_cfg_t ifu_sel;
  pmp_cfg_t lsu_sel;
  // effective load/store privilege
  logic     lsu_mach;
  // permission bit needed by the load/store access
  logic     lsu_perm;

  // allow rule shared by both ports
  function automatic logic port_allow(logic any_hit, logic mach,
                                      logic lock, logic perm);
    logic allow;
    if (!any_hit) begin
      // only machine mode passes without a match
      allow = mach;
    end else begin
      // unlocked entries do not bind machine mode
      allow = (mach & ~lock) | perm;
    end
    return allow;
  endfunction

  // walk down so the lowest hit index is left
  always_comb begin
    ifu_sel = '0;
    lsu_sel = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (ifu_hit[i]) begin
        ifu_sel = cfg[i];
      end
      if (lsu_hit[i]) begin
        lsu_sel = cfg[i];
      end
    end
  end

  // mprv makes loads/stores run with mpp privilege
  assign lsu_mach = mstatus_mprv ? (mstatus_mpp == MPP_MACHINE) : mach_mode;

  assign lsu_perm = lsu_write ? lsu_sel.write : lsu_sel.read;

  // fetch needs exec
  assign ifu_deny = ~port_allow(|ifu_hit, ifu_machine_mode, ifu_sel.lock, ifu_sel.exec);
  assign lsu_deny = ~port_allow(|lsu_hit, lsu_mach, lsu_sel.lock, lsu_perm);

endmodule

// File: pmp_pkg.sv
// pmp_pkg: shared widths, csr field types and the address match mode enum
package pmp_pkg;

  // one pmpcfg word holds this many entry bytes
  localparam int CFG_PER_CSR = 4;

  // pmpcfg selects first, then one pmpaddr select per entry
  // 8/4 + 8 for the default of eight entries
  localparam int CSR_SEL_W = 10;

  // mstatus.mpp encoding of machine mode
  localparam logic [1:0] MPP_MACHINE = 2'b11;

  // physical byte address from fetch or load/store
  typedef logic [31:0] paddr_t;

  // pmpaddr value, word address bits 31:2
  typedef logic [29:0] pmpaddr_t;

  // csr read/write data word
  typedef logic [31:0] csr_data_t;

  // one-hot csr select
  typedef logic [CSR_SEL_W-1:0] csr_sel_t;

  // one pmpcfg byte as seen on the csr bus
  typedef logic [7:0] cfg_byte_t;

  // the A field of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // stored entry config without reserved bits 6:5
  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // csr access from the core
  typedef struct packed {
    csr_sel_t  sel;
    logic      wen;
    csr_data_t wdata;
  } pmp_csr_req_t;

endpackage

// File: pmp_top.sv
// pmp_top: pmp unit top with csr control, storage, matchers and permission check
`timescale 1ns/1ps

module pmp_top
  import pmp_pkg::*;
#(
  parameter int NUM_ENTRIES = 8
) (
  input  logic         cpuclk,
  input  logic         rst,
  input  pmp_csr_req_t csr_req,
  input  paddr_t       ifu_addr,
  input  logic         ifu_machine_mode,
  input  paddr_t       lsu_addr,
  input  logic         lsu_write,
  input  logic         mach_mode,
  input  logic         mstatus_mprv,
  input  logic [1:0]   mstatus_mpp,
  output csr_data_t    csr_rdata,
  output logic         ifu_deny,
  output logic         lsu_deny
);

  // write path
  logic     [NUM_ENTRIES-1:0] cfg_wen;
  logic     [NUM_ENTRIES-1:0] addr_wen;
  csr_data_t                  wdata;
  // stored entries
  pmp_cfg_t [NUM_ENTRIES-1:0] cfg;
  pmpaddr_t [NUM_ENTRIES-1:0] addr;
  // ge chain with bit 0 as the implicit zero bottom of entry 0
  logic     [NUM_ENTRIES:0]   ifu_ge_chain;
  logic     [NUM_ENTRIES:0]   lsu_ge_chain;
  // per-entry hits
  logic     [NUM_ENTRIES-1:0] ifu_hit;
  logic     [NUM_ENTRIES-1:0] lsu_hit;

  assign ifu_ge_chain[0] = 1'b1;
  assign lsu_ge_chain[0] = 1'b1;

  pmp_csr_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) pmp_csr_ctrl_i (
    .csr_req   (csr_req),
    .cfg       (cfg),
    .addr      (addr),
    .cfg_wen   (cfg_wen),
    .addr_wen  (addr_wen),
    .wdata     (wdata),
    .csr_rdata (csr_rdata)
  );

  pmp_entry_regs #(.NUM_ENTRIES(NUM_ENTRIES)) pmp_entry_regs_i (
    .cpuclk   (cpuclk),
    .rst      (rst),
    .cfg_wen  (cfg_wen),
    .addr_wen (addr_wen),
    .wdata    (wdata),
    .cfg      (cfg),
    .addr     (addr)
  );

  // one matcher per entry with ge of entry i as the bottom of entry i+1
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_match
    pmp_addr_match pmp_addr_match_i (
      .cfg_mode    (cfg[i].mode),
      .entry_addr  (addr[i]),
      .ifu_addr    (ifu_addr),
      .lsu_addr    (lsu_addr),
      .ifu_ge_prev (ifu_ge_chain[i]),
      .lsu_ge_prev (lsu_ge_chain[i]),
      .ifu_ge      (ifu_ge_chain[i+1]),
      .lsu_ge      (lsu_ge_chain[i+1]),
      .ifu_hit     (ifu_hit[i]),
      .lsu_hit     (lsu_hit[i])
    );
  end

  pmp_perm_check #(.NUM_ENTRIES(NUM_ENTRIES)) pmp_perm_check_i (
    .cfg              (cfg),
    .ifu_hit          (ifu_hit),
    .lsu_hit          (lsu_hit),
    .ifu_machine_mode (ifu_machine_mode),
    .lsu_write        (lsu_write),
    .mach_mode        (mach_mode),
    .mstatus_mprv     (mstatus_mprv),
    .mstatus_mpp      (mstatus_mpp),
    .ifu_deny         (ifu_deny),
    .lsu_deny         (lsu_deny)
  );

endmodule

// File: run.sh
#!/bin/sh
# build with verilator, run, then judge the run by sim.log
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_pmp -f compile.f > build.log 2>&1 &&
./obj_dir/Vtb_pmp > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "RESULT: FAIL"; exit 1; } || echo "RESULT: PASS"

// File: tb_pmp.sv
// tb_pmp: testbench top with random stimulus, shadow model, check task and reporting
`timescale 1ns/1ps

module tb_pmp
  import pmp_pkg::*;
();

  localparam int N = 8;

  logic         cpuclk;
  logic         por_rst;
  logic         tb_rst;
  logic         rst_dut;
  pmp_csr_req_t csr_req;
  paddr_t       ifu_addr;
  logic         ifu_machine_mode;
  paddr_t       lsu_addr;
  logic         lsu_write;
  logic         mach_mode;
  logic         mstatus_mprv;
  logic [1:0]   mstatus_mpp;
  csr_data_t    csr_rdata;
  logic         ifu_deny;
  logic         lsu_deny;

  // shadow of the csr state with cfg in csr byte layout
  logic [7:0]   m_cfg [N];
  pmpaddr_t     m_addr [N];
  int           errors;
  int           tests_pass;
  int           tests_fail;

  // power-on reset or a reset pulse from the tests
  assign rst_dut = por_rst | tb_rst;

  tb_pmp_clk tb_pmp_clk_i (
    .cpuclk (cpuclk),
    .rst    (por_rst)
  );

  pmp_top #(.NUM_ENTRIES(N)) pmp_top_i (
    .cpuclk           (cpuclk),
    .rst              (rst_dut),
    .csr_req          (csr_req),
    .ifu_addr         (ifu_addr),
    .ifu_machine_mode (ifu_machine_mode),
    .lsu_addr         (lsu_addr),
    .lsu_write        (lsu_write),
    .mach_mode        (mach_mode),
    .mstatus_mprv     (mstatus_mprv),
    .mstatus_mpp      (mstatus_mpp),
    .csr_rdata        (csr_rdata),
    .ifu_deny         (ifu_deny),
    .lsu_deny         (lsu_deny)
  );

  task automatic model_reset();
    for (int e = 0; e < N; e++) begin
      m_cfg[e] = '0;
      m_addr[e] = '0;
    end
  endtask

  // csr write as the lock rules allow it
  task automatic model_write(input int sel, input csr_data_t d);
    int e;
    if (sel < N / 4) begin
      for (int b = 0; b < 4; b++) begin
        // reserved bits 6:5 never stored
        if (!m_cfg[sel*4+b][7]) begin
          m_cfg[sel*4+b] = d[8*b +: 8] & 8'h9f;
        end
      end
    end else begin
      e = sel - N / 4;
      // own lock or a locked TOR entry right above
      if (!(m_cfg[e][7] || (e < N - 1 && m_cfg[e+1][7] && m_cfg[e+1][4:3] == 2'b01))) begin
        m_addr[e] = d[29:0];
      end
    end
  endtask

  function automatic csr_data_t model_read(input int sel);
    if (sel < N / 4) begin
      return {m_cfg[sel*4+3], m_cfg[sel*4+2], m_cfg[sel*4+1], m_cfg[sel*4]};
    end
    return {2'b00, m_addr[sel - N / 4]};
  endfunction

  // care bits of a napot region
  // k trailing ones give 2^(k+1) words
  function automatic pmpaddr_t napot_mask(input pmpaddr_t a);
    int k;
    k = 0;
    while (k < 30 && a[k]) begin
      k++;
    end
    return {30{1'b1}} << (k + 1);
  endfunction

  // need is 0 read, 1 write, 2 exec
  function automatic logic model_deny(input paddr_t a, input logic mach, input int need);
    pmpaddr_t w;
    pmpaddr_t lo;
    pmpaddr_t mk;
    logic     hit;
    w = a[31:2];
    for (int e = 0; e < N; e++) begin
      // TOR bottom is the previous entry or zero for entry 0
      lo = (e == 0) ? '0 : m_addr[e-1];
      mk = napot_mask(m_addr[e]);
      case (m_cfg[e][4:3])
        2'b01:   hit = (w >= lo) && (w < m_addr[e]);
        2'b10:   hit = (w == m_addr[e]);
        2'b11:   hit = (w & mk) == (m_addr[e] & mk);
        default: hit = 1'b0;
      endcase
      // first hit decides
      // unlocked entries leave machine mode alone
      if (hit) begin
        return !((mach && !m_cfg[e][7]) || m_cfg[e][need]);
      end
    end
    return !mach;
  endfunction

  task automatic check(input csr_data_t actual, input csr_data_t expected, input string msg);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  // one ns after the rising edge
  task automatic tick();
    @(posedge cpuclk);
    #1;
  endtask

  task automatic csr_write(input int sel, input csr_data_t d);
    tick();
    csr_req.sel = csr_sel_t'(1) << sel;
    csr_req.wen = 1'b1;
    csr_req.wdata = d;
    model_write(sel, d);
    tick();
    csr_req.wen = 1'b0;
  endtask

  // caller is already 1 ns past an edge
  task automatic read_check(input int sel);
    csr_req.sel = csr_sel_t'(1) << sel;
    #10;
    check(csr_rdata, model_read(sel), $sformatf("csr read sel %0d", sel));
  endtask

  task automatic access_check(input paddr_t ia, input logic im, input paddr_t la,
                              input logic lw, input logic mm, input logic mprv,
                              input logic [1:0] mpp);
    logic lm;
    tick();
    ifu_addr = ia;
    ifu_machine_mode = im;
    lsu_addr = la;
    lsu_write = lw;
    mach_mode = mm;
    mstatus_mprv = mprv;
    mstatus_mpp = mpp;
    #10;
    // mprv hands loads and stores the mpp privilege
    lm = mprv ? (mpp == 2'b11) : mm;
    check(32'(ifu_deny), 32'(model_deny(ia, im, 2)), $sformatf("ifu_deny at %h", ia));
    check(32'(lsu_deny), 32'(model_deny(la, lm, lw ? 1 : 0)), $sformatf("lsu_deny at %h", la));
  endtask

  // mostly near an entry boundary and sometimes anywhere
  function automatic paddr_t edge_addr();
    pmpaddr_t w;
    int       e;
    e = int'($urandom % N);
    w = m_addr[e] & ({30{1'b1}} << ($urandom % 6));
    w = w + 30'($urandom % 5) - 30'd2;
    if ($urandom % 5 == 0) begin
      return $urandom;
    end
    return {w, 2'($urandom)};
  endfunction

  // unlocked entries with addresses in one small window so regions overlap
  task automatic program_entries();
    csr_data_t d;
    for (int e = 0; e < N; e++) begin
      csr_write(N / 4 + e, {2'b00, 30'h0004_0000 | 30'($urandom & 32'hff)});
    end
    for (int c = 0; c < N / 4; c++) begin
      for (int b = 0; b < 4; b++) begin
        d[8*b +: 8] = {3'b000, 2'(1 + $urandom % 3), 3'($urandom)};
      end
      csr_write(c, d);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_pass++;
      $display("PASS  %s", name);
    end else begin
      tests_fail++;
      $display("FAIL  %s, %0d mismatches", name, errors - err_start);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    for (int s = 0; s < CSR_SEL_W; s++) begin
      tick();
      read_check(s);
    end
    // only machine mode gets through with nothing configured
    for (int k = 0; k < 20; k++) begin
      access_check($urandom, 1'b1, $urandom, 1'($urandom), 1'b1, 1'b0, 2'b00);
      access_check($urandom, 1'b0, $urandom, 1'($urandom), 1'b0, 1'b0, 2'b00);
    end
    finish_test("reset state", e0);
  endtask

  task automatic test_csr_rw();
    int        e0;
    int        s;
    csr_data_t d;
    e0 = errors;
    for (int k = 0; k < 40; k++) begin
      s = int'($urandom % CSR_SEL_W);
      d = $urandom;
      // keep every lock clear
      if (s < N / 4) begin
        d = d & 32'h7f7f7f7f;
      end
      csr_write(s, d);
      read_check(s);
    end
    tick();
    csr_req.sel = '0;
    #10;
    check(csr_rdata, 32'h0, "csr read with no select");
    finish_test("csr write and read back", e0);
  endtask

  task automatic test_region_match();
    int e0;
    e0 = errors;
    program_entries();
    for (int k = 0; k < 200; k++) begin
      access_check(edge_addr(), 1'b0, edge_addr(), 1'($urandom), 1'b0, 1'b0, 2'b00);
    end
    finish_test("user mode region match", e0);
  endtask

  task automatic test_locks();
    int e0;
    e0 = errors;
    // known bounds so the locked NA4 and TOR regions are reachable
    csr_write(N / 4 + 1, 32'h0004_0040);
    csr_write(N / 4 + 2, 32'h0004_0080);
    csr_write(N / 4 + 3, 32'h0004_0100);
    // entry0 NAPOT RW, entry1 locked NA4 R, entry2 NAPOT R, entry3 locked TOR XR
    csr_write(0, 32'h8d19911b);
    // entry0 left OFF so it cannot shadow entry1
    csr_write(0, $urandom & 32'h7f7f7f67);
    read_check(0);
    // addr1 and addr3 locked and addr2 the bottom of locked TOR 3
    for (int e = 0; e < 5; e++) begin
      csr_write(N / 4 + e, $urandom);
      read_check(N / 4 + e);
    end
    for (int k = 0; k < 100; k++) begin
      access_check(edge_addr(), 1'b1, edge_addr(), 1'($urandom), 1'b1, 1'b0, 2'b00);
    end
    // reset pulse over 4 edges
    tick();
    tb_rst = 1'b1;
    repeat (4) tick();
    tb_rst = 1'b0;
    model_reset();
    for (int s = 0; s < CSR_SEL_W; s++) begin
      tick();
      read_check(s);
    end
    csr_write(0, 32'h0b0b0b0b);
    read_check(0);
    csr_write(N / 4 + 3, $urandom);
    read_check(N / 4 + 3);
    finish_test("lock rules", e0);
  endtask

  task automatic test_lsu_priv();
    int e0;
    e0 = errors;
    program_entries();
    // mprv set with a random mach_mode that must be ignored
    for (int k = 0; k < 150; k++) begin
      access_check(edge_addr(), 1'($urandom), edge_addr(), 1'($urandom),
                   1'($urandom), 1'b1, 2'($urandom));
    end
    finish_test("load/store privilege", e0);
  endtask

  initial begin
    logic ok;
    int   n;
    errors = 0;
    tests_pass = 0;
    tests_fail = 0;
    void'($urandom(32'h4e3c0532));
    tb_rst = 1'b0;
    csr_req = '0;
    ifu_addr = '0;
    ifu_machine_mode = 1'b0;
    lsu_addr = '0;
    lsu_write = 1'b0;
    mach_mode = 1'b0;
    mstatus_mprv = 1'b0;
    mstatus_mpp = 2'b00;
    model_reset();
    // bounded wait for reset release
    n = 0;
    while (rst_dut !== 1'b0 && n < 20) begin
      @(posedge cpuclk);
      n++;
    end
    ok = (rst_dut === 1'b0);
    if (!ok) begin
      $display("timeout: reset was never released");
      $display("Test failed");
    end else begin
      test_reset_state();
      test_csr_rw();
      test_region_match();
      test_locks();
      test_lsu_priv();
      $display("passing tests: %0d, failing tests: %0d", tests_pass, tests_fail);
      if (tests_fail == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
    end
    $finish;
  end

endmodule

// File: tb_pmp_clk.sv
// tb_pmp_clk: testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_pmp_clk (
  output logic cpuclk,
  output logic rst
);

  // 20 ns period
  initial begin
    cpuclk = 1'b0;
    forever #10 cpuclk = ~cpuclk;
  end

  // reset held over the first 4 rising edges
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge cpuclk);
    #1 rst = 1'b0;
  end

endmodule
